//--- rtl/pitaya_pkg.sv
//////////////////////////////
// Shared widths, register map and bus types for the ADC clock domain
// Register offsets are byte offsets inside one 256-byte region
// mux_cfg_t field order follows the REG_MUX bit layout
//////////////////////////////

package pitaya_pkg;

  //////////////////////////////
  // Data widths
  //////////////////////////////

  // Raw ADC sample, low two bits reserved
  localparam int unsigned ADC_W  = 16;
  // DAC sample, two's complement inside the design
  localparam int unsigned DAC_W  = 14;
  // PDM level
  localparam int unsigned PDM_W  = 8;
  // Upper bound on analog channels carried by mux_cfg_t
  localparam int unsigned MAX_CH = 4;

  //////////////////////////////
  // Register map
  //////////////////////////////

  // Identification word
  localparam logic [31:0] ID_VALUE = 32'h5250_0001;

  // Regions, selected by PADDR[11:8]
  localparam logic [3:0] SLOT_CTL = 4'd0;
  localparam logic [3:0] SLOT_PDM = 4'd1;

  // Control region offsets
  localparam logic [7:0] REG_ID  = 8'h00;
  localparam logic [7:0] REG_MUX = 8'h04;
  // DC level per channel, further channels continue at the same stride
  localparam logic [7:0] REG_DC0 = 8'h08;
  localparam logic [7:0] REG_DC1 = 8'h0C;

  //////////////////////////////
  // Bus and stream types
  //////////////////////////////

  // APB request, driven by the master
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  // APB response, valid in the access cycle
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // Generator select in bits 7..4, loopback in bits 3..0
  typedef struct packed {
    logic [MAX_CH-1:0] gen;
    logic [MAX_CH-1:0] loop;
  } mux_cfg_t;

  // Generator sample, no ready
  typedef struct packed {
    logic                    valid;
    logic signed [DAC_W-1:0] data;
  } gen_smp_t;

endpackage

//--- rtl/apb_decoder.sv
`timescale 1ns/1ps
//////////////////////////////
// APB region decoder, purely combinational
// Region from PADDR[11:8], unmapped regions answer with an error
//////////////////////////////

module apb_decoder (
  input  pitaya_pkg::apb_req_t apb_req_i,
  output pitaya_pkg::apb_rsp_t apb_rsp_o,
  // Control register region
  output pitaya_pkg::apb_req_t ctl_req_o,
  input  pitaya_pkg::apb_rsp_t ctl_rsp_i,
  // PDM register region
  output pitaya_pkg::apb_req_t pdm_req_o,
  input  pitaya_pkg::apb_rsp_t pdm_rsp_i
);

  import pitaya_pkg::*;

  // Answer for regions with no slave behind them
  localparam apb_rsp_t RSP_ERR = '{prdata: '0, pready: 1'b1, pslverr: 1'b1};

  logic [3:0] slot;

  assign slot = apb_req_i.paddr[11:8];

  //////////////////////////////
  // Request fan-out
  //////////////////////////////

  always_comb begin
    ctl_req_o = apb_req_i;
    pdm_req_o = apb_req_i;
    // Only psel is gated, penable goes to both
    ctl_req_o.psel = apb_req_i.psel & (slot == SLOT_CTL);
    pdm_req_o.psel = apb_req_i.psel & (slot == SLOT_PDM);
  end

  //////////////////////////////
  // Response mux
  //////////////////////////////

  always_comb begin
    case (slot)
      SLOT_CTL: apb_rsp_o = ctl_rsp_i;
      SLOT_PDM: apb_rsp_o = pdm_rsp_i;
      default:  apb_rsp_o = RSP_ERR;
    endcase
  end

  // Access phase must follow a setup phase, so psel is already high when penable rises
  a_apb_setup: assert property (@(posedge apb_req_i.penable) apb_req_i.psel)
    else $error("APB penable raised without psel");

endmodule

//--- rtl/ctl_regs.sv
`timescale 1ns/1ps
//////////////////////////////
// Control registers: ID, loopback/generator select, DC levels
// Writing REG_ID flags pslverr and changes nothing
// Unmapped offsets read zero without error
//////////////////////////////

module ctl_regs #(
  parameter int unsigned NCH = 2
)(
  input  logic                                adc_clk,
  input  logic                                top_rst,
  input  pitaya_pkg::apb_req_t                apb_req_i,
  output pitaya_pkg::apb_rsp_t                apb_rsp_o,
  output pitaya_pkg::mux_cfg_t                mux_cfg_o,
  output logic signed [pitaya_pkg::DAC_W-1:0] dc_lvl_o [NCH]
);

  import pitaya_pkg::*;

  // Select bits that exist for this channel count
  localparam logic [MAX_CH-1:0] CH_MSK  = MAX_CH'((1 << NCH) - 1);
  // Address step between DC registers
  localparam logic [7:0]        DC_STEP = REG_DC1 - REG_DC0;

  logic [7:0]              offs;
  logic                    acc_cyc;
  logic                    id_wr;
  logic                    wr_ok;
  logic [31:0]             rd_dat;
  mux_cfg_t                mux_q;
  logic signed [DAC_W-1:0] dc_q [NCH];

  assign offs    = apb_req_i.paddr[7:0];
  // Access cycle of a selected transfer
  assign acc_cyc = apb_req_i.psel & apb_req_i.penable;
  assign id_wr   = apb_req_i.pwrite & (offs == REG_ID);
  // Erroneous writes are dropped
  assign wr_ok   = acc_cyc & apb_req_i.pwrite & ~id_wr;

  //////////////////////////////
  // Write side
  //////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      mux_q <= '0;
      for (int n = 0; n < NCH; n++) begin
        dc_q[n] <= '0;
      end
    end else if (wr_ok) begin
      // Fields of missing channels stay zero
      if (offs == REG_MUX) begin
        mux_q <= apb_req_i.pwdata[$bits(mux_cfg_t)-1:0] & {CH_MSK, CH_MSK};
      end
      for (int n = 0; n < NCH; n++) begin
        if (offs == REG_DC0 + DC_STEP * 8'(n)) begin
          dc_q[n] <= apb_req_i.pwdata[DAC_W-1:0];
        end
      end
    end
  end

  //////////////////////////////
  // Read side
  //////////////////////////////

  always_comb begin
    rd_dat = '0;
    case (offs)
      REG_ID:  rd_dat = ID_VALUE;
      REG_MUX: rd_dat = 32'(mux_q);
      default: begin
        // DC level comes back zero extended
        for (int n = 0; n < NCH; n++) begin
          if (offs == REG_DC0 + DC_STEP * 8'(n)) begin
            rd_dat = {{(32 - DAC_W){1'b0}}, dc_q[n]};
          end
        end
      end
    endcase
  end

  // Zero wait states
  assign apb_rsp_o = '{prdata: rd_dat, pready: 1'b1, pslverr: acc_cyc & id_wr};

  assign mux_cfg_o = mux_q;
  assign dc_lvl_o  = dc_q;

endmodule

//--- rtl/pdm_bank.sv
`timescale 1ns/1ps
//////////////////////////////
// PDM level registers and first-order modulators
// Channel n at offset 4*n, only the low PDM_W bits are kept
// Output is high for exactly level cycles out of 2**PDM_W
//////////////////////////////

module pdm_bank #(
  parameter int unsigned PDM_CHN = 4
)(
  input  logic                 adc_clk,
  input  logic                 top_rst,
  input  pitaya_pkg::apb_req_t apb_req_i,
  output pitaya_pkg::apb_rsp_t apb_rsp_o,
  output logic [PDM_CHN-1:0]   pdm_o
);

  import pitaya_pkg::*;

  logic [3:0]       idx;
  logic             in_rng;
  logic             wr_en;
  logic [31:0]      rd_dat;
  logic [PDM_W-1:0] lvl_q [PDM_CHN];
  logic [PDM_W-1:0] acc_q [PDM_CHN];
  // Accumulator plus level, carry on top
  logic [PDM_W:0]   sum_c [PDM_CHN];

  //////////////////////////////
  // Register array
  //////////////////////////////

  // Word index, offsets above the array are ignored
  assign idx    = apb_req_i.paddr[5:2];
  assign in_rng = (apb_req_i.paddr[7:6] == 2'b00) && (32'(idx) < PDM_CHN);
  assign wr_en  = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite & in_rng;

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      for (int n = 0; n < PDM_CHN; n++) begin
        lvl_q[n] <= '0;
      end
    end else if (wr_en) begin
      for (int n = 0; n < PDM_CHN; n++) begin
        if (idx == 4'(n)) begin
          lvl_q[n] <= apb_req_i.pwdata[PDM_W-1:0];
        end
      end
    end
  end

  always_comb begin
    rd_dat = '0;
    for (int n = 0; n < PDM_CHN; n++) begin
      if (in_rng && (idx == 4'(n))) begin
        rd_dat = 32'(lvl_q[n]);
      end
    end
  end

  // No error cases in this region
  assign apb_rsp_o = '{prdata: rd_dat, pready: 1'b1, pslverr: 1'b0};

  //////////////////////////////
  // Modulators
  //////////////////////////////

  always_comb begin
    for (int n = 0; n < PDM_CHN; n++) begin
      sum_c[n] = {1'b0, acc_q[n]} + {1'b0, lvl_q[n]};
    end
  end

  // Carry out becomes the pulse
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      for (int n = 0; n < PDM_CHN; n++) begin
        acc_q[n] <= '0;
        pdm_o[n] <= 1'b0;
      end
    end else begin
      for (int n = 0; n < PDM_CHN; n++) begin
        acc_q[n] <= sum_c[n][PDM_W-1:0];
        pdm_o[n] <= sum_c[n][PDM_W];
      end
    end
  end

  // Zero level written, no pulse once it reaches the modulator
  for (genvar n = 0; n < PDM_CHN; n++) begin : g_chk
    a_pdm_zero: assert property (@(posedge adc_clk) disable iff (top_rst)
      (wr_en && (idx == 4'(n)) && (apb_req_i.pwdata[PDM_W-1:0] == '0)) |=> ##1 !pdm_o[n])
      else $error("PDM channel %0d pulses at zero level", n);
  end

endmodule

//--- rtl/adc_frontend.sv
`timescale 1ns/1ps
//////////////////////////////
// ADC input registers with digital loopback
// Raw ADC data is offset binary with inverted slope
// Loopback puts the DAC sample in the top bits, low bits zero
//////////////////////////////

module adc_frontend #(
  parameter int unsigned NCH = 2
)(
  input  logic                                     adc_clk,
  input  logic                                     top_rst,
  // Raw samples from the converter pins
  input  logic [NCH-1:0][pitaya_pkg::ADC_W-1:0]    adc_dat_i,
  input  logic [NCH-1:0]                           loop_i,
  // Registered DAC samples for loopback
  input  logic signed [pitaya_pkg::DAC_W-1:0]      dac_smp_i [NCH],
  output logic signed [pitaya_pkg::ADC_W-1:0]      adc_dat_o [NCH]
);

  import pitaya_pkg::*;

  // Reserved low bits of the ADC word
  localparam int unsigned RSV_W = ADC_W - DAC_W;

  logic signed [ADC_W-1:0] raw_s [NCH];
  logic signed [ADC_W-1:0] lpb_s [NCH];

  //////////////////////////////
  // Conversion
  //////////////////////////////

  always_comb begin
    for (int i = 0; i < NCH; i++) begin
      // Keep MSB, invert the rest to get two's complement
      raw_s[i] = {adc_dat_i[i][ADC_W-1], ~adc_dat_i[i][ADC_W-2:0]};
      // DAC scale to ADC scale
      lpb_s[i] = {dac_smp_i[i], {RSV_W{1'b0}}};
    end
  end

  //////////////////////////////
  // Input register and loopback mux
  //////////////////////////////

  // One cycle from pin to output
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      for (int i = 0; i < NCH; i++) begin
        adc_dat_o[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NCH; i++) begin
        adc_dat_o[i] <= loop_i[i] ? lpb_s[i] : raw_s[i];
      end
    end
  end

endmodule

//--- rtl/dac_frontend.sv
`timescale 1ns/1ps
//////////////////////////////
// DAC source select, output register and DAC reset
// Generator stream is always accepted, invalid cycles hold the last sample
// One DAC bus per channel, no DDR interleave
//////////////////////////////

module dac_frontend #(
  parameter int unsigned NCH = 2
)(
  input  logic                                  adc_clk,
  input  logic                                  top_rst,
  input  pitaya_pkg::gen_smp_t [NCH-1:0]        gen_i,
  // High selects the DC level
  input  logic [NCH-1:0]                        gen_sel_i,
  input  logic signed [pitaya_pkg::DAC_W-1:0]   dc_lvl_i [NCH],
  // Signed samples, also used for loopback
  output logic signed [pitaya_pkg::DAC_W-1:0]   dac_smp_o [NCH],
  output logic [NCH-1:0][pitaya_pkg::DAC_W-1:0] dac_dat_o,
  output logic                                  dac_rst_o
);

  import pitaya_pkg::*;

  // Last valid generator sample
  logic signed [DAC_W-1:0] gen_hold [NCH];
  logic signed [DAC_W-1:0] gen_cur  [NCH];
  logic signed [DAC_W-1:0] src      [NCH];

  //////////////////////////////
  // Source select
  //////////////////////////////

  always_comb begin
    for (int i = 0; i < NCH; i++) begin
      // A new valid sample goes straight through
      gen_cur[i] = gen_i[i].valid ? gen_i[i].data : gen_hold[i];
      src[i]     = gen_sel_i[i] ? dc_lvl_i[i] : gen_cur[i];
    end
  end

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      for (int i = 0; i < NCH; i++) begin
        gen_hold[i]  <= '0;
        dac_smp_o[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NCH; i++) begin
        if (gen_i[i].valid) begin
          gen_hold[i] <= gen_i[i].data;
        end
        dac_smp_o[i] <= src[i];
      end
    end
  end

  // Two's complement to DAC offset code, negative slope
  always_comb begin
    for (int i = 0; i < NCH; i++) begin
      dac_dat_o[i] = {dac_smp_o[i][DAC_W-1], ~dac_smp_o[i][DAC_W-2:0]};
    end
  end

  //////////////////////////////
  // DAC reset
  //////////////////////////////

  // Set by reset, clears at the first edge after release
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dac_rst_o <= 1'b1;
    end else begin
      dac_rst_o <= 1'b0;
    end
  end

  // Upstream generator must drive valid once out of reset
  for (genvar i = 0; i < NCH; i++) begin : g_chk
    a_gen_valid: assert property (@(posedge adc_clk) disable iff (top_rst)
      !$isunknown(gen_i[i].valid))
      else $error("Generator %0d valid is unknown", i);
  end

endmodule

//--- rtl/pitaya_top.sv
`timescale 1ns/1ps
//////////////////////////////
// ADC clock domain top level, everything runs on adc_clk
// NCH from 1 to 4, PDM_CHN from 1 to 16
//////////////////////////////

module pitaya_top #(
  parameter int unsigned NCH     = 2,
  parameter int unsigned PDM_CHN = 4
)(
  input  logic                                  adc_clk,
  input  logic                                  top_rst,
  // Register bus
  input  pitaya_pkg::apb_req_t                  apb_req_i,
  output pitaya_pkg::apb_rsp_t                  apb_rsp_o,
  // ADC
  input  logic [NCH-1:0][pitaya_pkg::ADC_W-1:0] adc_dat_i,
  output logic signed [pitaya_pkg::ADC_W-1:0]   adc_dat_o [NCH],
  // Generator stream and DAC
  input  pitaya_pkg::gen_smp_t [NCH-1:0]        gen_i,
  output logic [NCH-1:0][pitaya_pkg::DAC_W-1:0] dac_dat_o,
  output logic                                  dac_rst_o,
  // Pulse-density outputs
  output logic [PDM_CHN-1:0]                    pdm_o
);

  import pitaya_pkg::*;

  //////////////////////////////
  // Local wires
  //////////////////////////////

  apb_req_t                ctl_req;
  apb_rsp_t                ctl_rsp;
  apb_req_t                pdm_req;
  apb_rsp_t                pdm_rsp;
  mux_cfg_t                mux_cfg;
  logic signed [DAC_W-1:0] dc_lvl  [NCH];
  // Registered DAC samples, fed back for loopback
  logic signed [DAC_W-1:0] dac_smp [NCH];

  //////////////////////////////
  // Register bus
  //////////////////////////////

  apb_decoder u_dec (
    .apb_req_i (apb_req_i),
    .apb_rsp_o (apb_rsp_o),
    .ctl_req_o (ctl_req),
    .ctl_rsp_i (ctl_rsp),
    .pdm_req_o (pdm_req),
    .pdm_rsp_i (pdm_rsp)
  );

  ctl_regs #(.NCH (NCH)) u_ctl (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .apb_req_i (ctl_req),
    .apb_rsp_o (ctl_rsp),
    .mux_cfg_o (mux_cfg),
    .dc_lvl_o  (dc_lvl)
  );

  pdm_bank #(.PDM_CHN (PDM_CHN)) u_pdm (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .apb_req_i (pdm_req),
    .apb_rsp_o (pdm_rsp),
    .pdm_o     (pdm_o)
  );

  //////////////////////////////
  // Analog front ends
  //////////////////////////////

  adc_frontend #(.NCH (NCH)) u_adc (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat_i),
    .loop_i    (mux_cfg.loop[NCH-1:0]),
    .dac_smp_i (dac_smp),
    .adc_dat_o (adc_dat_o)
  );

  dac_frontend #(.NCH (NCH)) u_dac (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .gen_i     (gen_i),
    .gen_sel_i (mux_cfg.gen[NCH-1:0]),
    .dc_lvl_i  (dc_lvl),
    .dac_smp_o (dac_smp),
    .dac_dat_o (dac_dat_o),
    .dac_rst_o (dac_rst_o)
  );

endmodule

//--- testbench/tb_checks.svh
//////////////////////////////
// Testbench helpers, included inside tb_top after its signals
// Uses adc_clk, apb_req, apb_rsp, lfsr_q and abort_run of tb_top
//////////////////////////////

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

//////////////////////////////
// Random bits
//////////////////////////////

// Galois form, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  if (s[0]) begin
    return (s >> 1) ^ 16'hB400;
  end
  return s >> 1;
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_q = lfsr_next(lfsr_q);
    r = {r[30:0], lfsr_q[0]};
  end
  return r;
endfunction

//////////////////////////////
// Reference model pieces
//////////////////////////////

// Raw ADC word to two's complement, MSB kept
function automatic logic [ADC_W-1:0] adc_conv(input logic [ADC_W-1:0] raw);
  return raw ^ {1'b0, {(ADC_W - 1){1'b1}}};
endfunction

// Signed DAC sample to DAC pin code, MSB kept
function automatic logic [DAC_W-1:0] dac_conv(input logic [DAC_W-1:0] smp);
  return smp ^ {1'b0, {(DAC_W - 1){1'b1}}};
endfunction

// DAC sample on the ADC scale, reserved low bits zero
function automatic logic [ADC_W-1:0] loop_shift(input logic [DAC_W-1:0] smp);
  return {smp, 2'b00};
endfunction

//////////////////////////////
// Compare and bus access
//////////////////////////////

task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
    abort_run();
  end
endtask

// Setup, access, then idle from the edge that ends the access
task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, input logic exp_err);
  @(posedge adc_clk);
  apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
  @(posedge adc_clk);
  apb_req.penable <= 1'b1;
  @(negedge adc_clk);
  check_eq("pready", 32'(apb_rsp.pready), 32'd1);
  check_eq("pslverr", 32'(apb_rsp.pslverr), 32'(exp_err));
  @(posedge adc_clk);
  apb_req <= APB_IDLE;
endtask

// Read data only matters when no error is expected
task automatic apb_read(input logic [11:0] addr, input logic [31:0] exp_dat, input logic exp_err);
  @(posedge adc_clk);
  apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
  @(posedge adc_clk);
  apb_req.penable <= 1'b1;
  @(negedge adc_clk);
  check_eq("pready", 32'(apb_rsp.pready), 32'd1);
  check_eq("pslverr", 32'(apb_rsp.pslverr), 32'(exp_err));
  if (!exp_err) begin
    check_eq($sformatf("prdata at 0x%03h", addr), apb_rsp.prdata, exp_dat);
  end
  @(posedge adc_clk);
  apb_req <= APB_IDLE;
endtask

`endif

//--- testbench/tb_top.sv
`timescale 1ns/1ps
//////////////////////////////
// Testbench for the ADC clock domain top level
// NCH = 2 and PDM_CHN = 4, the run stops at the first mismatch
//////////////////////////////

module tb_top;

  import pitaya_pkg::*;

  localparam int NCH        = 2;
  localparam int PDM_CHN    = 4;
  // Test lengths
  localparam int N_RAND     = 200;
  localparam int N_ROUNDS   = 8;
  localparam int PDM_ROUNDS = 2;
  // APB accesses in the sequence, three cycles each
  localparam int N_ACC    = 8 + N_ROUNDS * (2 + 2 * NCH) + 29 + 1 + NCH + PDM_CHN + 6 +
                            PDM_ROUNDS * 2 * PDM_CHN;
  localparam int STIM_CYC = 3 + 3 * N_ACC + 4 * N_RAND + PDM_ROUNDS * 258;
  localparam int TIMEOUT_CYC = 4 * STIM_CYC;
  // Existing loopback bits 3..0 and generator bits 7..4
  localparam logic [31:0] MUX_MSK = 32'((((1 << NCH) - 1) << 4) | ((1 << NCH) - 1));
  localparam apb_req_t    APB_IDLE = '0;

  logic                      adc_clk   = 1'b0;
  logic                      top_rst   = 1'b1;
  apb_req_t                  apb_req   = '0;
  apb_rsp_t                  apb_rsp;
  logic [NCH-1:0][ADC_W-1:0] adc_dat_i = '0;
  logic signed [ADC_W-1:0]   adc_dat_o [NCH];
  gen_smp_t [NCH-1:0]        gen_i     = '0;
  logic [NCH-1:0][DAC_W-1:0] dac_dat_o;
  logic                      dac_rst_o;
  logic [PDM_CHN-1:0]        pdm_o;

  logic [15:0]      lfsr_q   = 16'd44;
  int               cyc_cnt  = 0;
  logic             rst_prev = 1'b1;
  // Register shadows, updated once a write has landed
  logic [NCH-1:0]   sh_loop  = '0;
  logic [NCH-1:0]   sh_gen   = '0;
  logic [DAC_W-1:0] sh_dc    [NCH] = '{default: '0};
  logic [PDM_W-1:0] pdm_lvl  [PDM_CHN] = '{default: '0};
  // Model state, one cycle ahead of the outputs
  logic [ADC_W-1:0] exp_adc  [NCH];
  logic [DAC_W-1:0] exp_smp  [NCH];
  logic [DAC_W-1:0] gen_last [NCH];

  task automatic abort_run();
    $display("** FAIL **");
    $fatal(1, "Simulation stopped after an error");
  endtask

  `include "tb_checks.svh"

  initial begin
    forever #50 adc_clk = ~adc_clk;
  end

  pitaya_top #(.NCH (NCH), .PDM_CHN (PDM_CHN)) dut0 (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp),
    .adc_dat_i (adc_dat_i),
    .adc_dat_o (adc_dat_o),
    .gen_i     (gen_i),
    .dac_dat_o (dac_dat_o),
    .dac_rst_o (dac_rst_o),
    .pdm_o     (pdm_o)
  );

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  task automatic set_mux(input logic [31:0] val);
    apb_write({SLOT_CTL, REG_MUX}, val, 1'b0);
    sh_loop = val[NCH-1:0];
    sh_gen  = val[4 +: NCH];
  endtask

  task automatic set_dc(input int ch, input logic [31:0] val);
    apb_write({SLOT_CTL, REG_DC0 + 8'(4 * ch)}, val, 1'b0);
    sh_dc[ch] = val[DAC_W-1:0];
  endtask

  // New ADC word and generator sample on every channel each cycle
  task automatic drive_random(input int n);
    repeat (n) begin
      @(posedge adc_clk);
      for (int ch = 0; ch < NCH; ch++) begin
        adc_dat_i[ch]    <= 16'(rand_bits(16));
        gen_i[ch].valid  <= 1'(rand_bits(1));
        gen_i[ch].data   <= 14'(rand_bits(14));
      end
    end
  endtask

  // Count pulses over one full 256-cycle period
  task automatic count_pdm();
    int hits [PDM_CHN];
    for (int n = 0; n < PDM_CHN; n++) begin
      hits[n] = 0;
    end
    repeat (2) @(posedge adc_clk);
    repeat (256) begin
      @(negedge adc_clk);
      for (int n = 0; n < PDM_CHN; n++) begin
        hits[n] += int'(pdm_o[n]);
      end
    end
    for (int n = 0; n < PDM_CHN; n++) begin
      check_eq($sformatf("pdm_o[%0d] high count", n), 32'(hits[n]), 32'(pdm_lvl[n]));
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    logic [31:0] val;
    repeat (3) @(posedge adc_clk);
    top_rst <= 1'b0;
    // Reset values
    apb_read({SLOT_CTL, REG_ID}, ID_VALUE, 1'b0);
    apb_read({SLOT_CTL, REG_MUX}, '0, 1'b0);
    for (int ch = 0; ch < NCH; ch++) begin
      apb_read({SLOT_CTL, REG_DC0 + 8'(4 * ch)}, '0, 1'b0);
    end
    for (int n = 0; n < PDM_CHN; n++) begin
      apb_read({SLOT_PDM, 8'(4 * n)}, '0, 1'b0);
    end
    // Register write and readback
    repeat (N_ROUNDS) begin
      val = rand_bits(32);
      set_mux(val);
      apb_read({SLOT_CTL, REG_MUX}, val & MUX_MSK, 1'b0);
      for (int ch = 0; ch < NCH; ch++) begin
        val = rand_bits(32);
        set_dc(ch, val);
        apb_read({SLOT_CTL, REG_DC0 + 8'(4 * ch)}, val & 32'h3FFF, 1'b0);
      end
    end
    // Error responses
    apb_write({SLOT_CTL, REG_ID}, rand_bits(32), 1'b1);
    for (int r = 2; r < 16; r++) begin
      // Mapped offsets, so a leaking decode would hit a live register
      apb_write({4'(r), 8'(4 * (r % 4))}, rand_bits(32), 1'b1);
      apb_read({4'(r), 8'(rand_bits(8))}, '0, 1'b1);
    end
    // Rejected writes leave every register as it was
    apb_read({SLOT_CTL, REG_MUX}, (32'(sh_gen) << 4) | 32'(sh_loop), 1'b0);
    for (int ch = 0; ch < NCH; ch++) begin
      apb_read({SLOT_CTL, REG_DC0 + 8'(4 * ch)}, 32'(sh_dc[ch]), 1'b0);
    end
    for (int n = 0; n < PDM_CHN; n++) begin
      apb_read({SLOT_PDM, 8'(4 * n)}, 32'(pdm_lvl[n]), 1'b0);
    end
    // ADC path and generator source
    set_mux('0);
    drive_random(N_RAND);
    // DC source
    for (int ch = 0; ch < NCH; ch++) begin
      set_dc(ch, rand_bits(32));
    end
    set_mux(MUX_MSK & 32'hF0);
    drive_random(N_RAND);
    // Loopback of generator, then of DC level
    set_mux(MUX_MSK & 32'h0F);
    drive_random(N_RAND);
    set_mux(MUX_MSK);
    drive_random(N_RAND);
    // PDM duty
    repeat (PDM_ROUNDS) begin
      for (int n = 0; n < PDM_CHN; n++) begin
        val = rand_bits(32);
        apb_write({SLOT_PDM, 8'(4 * n)}, val, 1'b0);
        pdm_lvl[n] = val[PDM_W-1:0];
        apb_read({SLOT_PDM, 8'(4 * n)}, val & 32'hFF, 1'b0);
      end
      count_pdm();
    end
    $display("** PASS **");
    $finish;
  end

  //////////////////////////////
  // Output checker
  //////////////////////////////

  // Inputs seen at this negedge reach the outputs by the next one
  always @(negedge adc_clk) begin
    check_eq("dac_rst_o", 32'(dac_rst_o), 32'(top_rst | rst_prev));
    if (top_rst) begin
      check_eq("pdm_o", 32'(pdm_o), 32'd0);
      for (int ch = 0; ch < NCH; ch++) begin
        exp_adc[ch]  = '0;
        exp_smp[ch]  = '0;
        gen_last[ch] = '0;
      end
    end
    for (int ch = 0; ch < NCH; ch++) begin
      check_eq($sformatf("adc_dat_o[%0d]", ch), {16'h0, adc_dat_o[ch]}, {16'h0, exp_adc[ch]});
      check_eq($sformatf("dac_dat_o[%0d]", ch), {18'h0, dac_dat_o[ch]},
               {18'h0, dac_conv(exp_smp[ch])});
    end
    if (!top_rst) begin
      for (int ch = 0; ch < NCH; ch++) begin
        // Loopback takes the DAC sample now in the register
        exp_adc[ch] = sh_loop[ch] ? loop_shift(exp_smp[ch]) : adc_conv(adc_dat_i[ch]);
        if (gen_i[ch].valid) begin
          gen_last[ch] = gen_i[ch].data;
        end
        exp_smp[ch] = sh_gen[ch] ? sh_dc[ch] : gen_last[ch];
      end
    end
    rst_prev = top_rst;
  end

  // Run limit
  always @(posedge adc_clk) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= TIMEOUT_CYC) begin
      $display("Timeout after %0d cycles, the test sequence did not finish", cyc_cnt);
      abort_run();
    end
  end

endmodule

//--- verilog.f
+incdir+testbench
rtl/pitaya_pkg.sv
rtl/apb_decoder.sv
rtl/ctl_regs.sv
rtl/pdm_bank.sv
rtl/adc_frontend.sv
rtl/dac_frontend.sv
rtl/pitaya_top.sv
testbench/tb_top.sv

//--- Makefile
# Verilator build and run of the ADC clock domain testbench

SIM   := verilator
FLAGS := --binary --timing --assert -j 0
TOP   := tb_top
FLIST := verilog.f
BUILD := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

# Exit status of the simulation binary is the test result
test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
